// File: rtl/usb_pkg.sv
// USB device-side constants for a high-speed controller; only the data PIDs used by iso IN
`default_nettype none

package usb_pkg;

    // ==================================================
    // bus widths
    localparam int unsigned ENDPT_W   = 4;   // endpoint number
    localparam int unsigned TXLEN_W   = 12;  // transfer length, max 4095
    localparam int unsigned SETUP_LEN = 8;   // bytes in a setup packet

    // endpoint map of this function
    localparam logic [ENDPT_W-1:0] EP_CTRL  = 4'd0;
    localparam logic [ENDPT_W-1:0] EP_VIDEO = 4'd2;

    // data PIDs for high-bandwidth iso, 3 packets per microframe
    typedef enum logic [3:0] {
        DATA0 = 4'b0011,
        DATA1 = 4'b1011,
        DATA2 = 4'b0111
    } iso_pid_e;

    // video class request codes (bRequest)
    typedef enum logic [7:0] {
        SET_CUR = 8'h01,
        GET_CUR = 8'h81,
        GET_DEF = 8'h87
    } uvc_req_e;

endpackage

`default_nettype wire

// File: rtl/uvc_pkg.sv
// UVC 1.1 probe block (34 bytes), little-endian fields; only byte offsets used by the RTL are listed
`default_nettype none

package uvc_pkg;

    // ==================================================
    // addressing of the probe control
    localparam logic [7:0] VS_PROBE_CONTROL = 8'h01;  // wValue high byte
    localparam logic [7:0] VS_INTERFACE     = 8'h01;  // wIndex low byte

    localparam int unsigned PROBE_LEN   = 34;  // bytes in the probe block
    localparam int unsigned FIELD32_LEN = 4;   // bytes in a dword field

    // index into the block, 0..PROBE_LEN
    typedef logic [5:0] probe_idx_t;

    // ==================================================
    // byte offsets of the fields with non-zero defaults
    localparam int unsigned FORMAT_OFS     = 2;   // bFormatIndex
    localparam int unsigned FRAME_OFS      = 3;   // bFrameIndex
    localparam int unsigned INTERVAL_OFS   = 4;   // dwFrameInterval
    localparam int unsigned FRAME_SIZE_OFS = 18;  // dwMaxVideoFrameSize
    localparam int unsigned PAYLOAD_OFS    = 22;  // dwMaxPayloadTransferSize, 22..25
    localparam int unsigned CLOCK_OFS      = 26;  // dwClockFrequency

    // ==================================================
    // defaults returned until the host writes the block
    localparam logic [7:0]  DEF_FORMAT_INDEX   = 8'd1;
    localparam logic [7:0]  DEF_FRAME_INDEX    = 8'd1;
    localparam logic [31:0] DEF_FRAME_INTERVAL = 32'd333333;    // 100 ns units, 30 fps
    localparam logic [31:0] DEF_PAYLOAD        = 32'd1024;      // one HS iso packet
    localparam logic [31:0] DEF_CLOCK_FREQ     = 32'd60000000;  // PHY_CLKOUT rate

endpackage

`default_nettype wire

// File: rtl/uvc_probe_ctrl.sv
// EP0 probe control for interface 1 only; payload size is read-only, wLength is not checked
`timescale 1ns/1ps
`default_nettype none

module uvc_probe_ctrl #(
    parameter logic [31:0] MAX_FRAME_SIZE = 32'd614400
) (
    input  logic       PHY_CLKOUT,
    input  logic       RESET_IN,
    input  logic       setup_i,
    input  logic       ctrl_sel_i,
    input  logic [7:0] rxdat_i,
    input  logic       rxval_i,
    input  logic       rxact_i,
    input  logic       txact_i,
    input  logic       txpop_i,
    output logic [7:0] probe_dat_o,
    output logic       probe_send_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_WR_DATA,
        ST_RD_DATA
    } state_e;

    state_e              state;
    logic [7:0]          setup_buf [usb_pkg::SETUP_LEN];
    logic [3:0]          setup_cnt;
    logic [7:0]          probe_mem [uvc_pkg::PROBE_LEN];
    uvc_pkg::probe_idx_t idx;
    logic                addr_match;
    logic                is_get;
    logic                is_set;
    logic                wr_run;
    logic                rd_run;
    logic                wr_hit;

    // default content of one probe byte
    function automatic logic [7:0] def_byte(input int unsigned pos);
        logic [31:0] word;
        logic [31:0] shifted;
        int unsigned ofs;
        word = 32'd0;
        ofs  = pos;
        if (pos == uvc_pkg::FORMAT_OFS) begin
            word = {24'd0, uvc_pkg::DEF_FORMAT_INDEX};
        end else if (pos == uvc_pkg::FRAME_OFS) begin
            word = {24'd0, uvc_pkg::DEF_FRAME_INDEX};
        end else if (pos >= uvc_pkg::INTERVAL_OFS && pos < uvc_pkg::INTERVAL_OFS + 4) begin
            word = uvc_pkg::DEF_FRAME_INTERVAL;
            ofs  = uvc_pkg::INTERVAL_OFS;
        end else if (pos >= uvc_pkg::FRAME_SIZE_OFS && pos < uvc_pkg::FRAME_SIZE_OFS + 4) begin
            word = MAX_FRAME_SIZE;
            ofs  = uvc_pkg::FRAME_SIZE_OFS;
        end else if (pos >= uvc_pkg::PAYLOAD_OFS && pos < uvc_pkg::PAYLOAD_OFS + 4) begin
            word = uvc_pkg::DEF_PAYLOAD;
            ofs  = uvc_pkg::PAYLOAD_OFS;
        end else if (pos >= uvc_pkg::CLOCK_OFS && pos < uvc_pkg::CLOCK_OFS + 4) begin
            word = uvc_pkg::DEF_CLOCK_FREQ;
            ofs  = uvc_pkg::CLOCK_OFS;
        end
        shifted = word >> (8 * (pos - ofs));  // little-endian byte pick
        return shifted[7:0];
    endfunction

    // ==================================================
    // setup packet capture
    assign addr_match = (setup_buf[4] == uvc_pkg::VS_INTERFACE) &&
                        (setup_buf[3] == uvc_pkg::VS_PROBE_CONTROL);  // wIndex lo, wValue hi
    assign is_get = (setup_buf[1] == usb_pkg::GET_CUR) || (setup_buf[1] == usb_pkg::GET_DEF);
    assign is_set = (setup_buf[1] == usb_pkg::SET_CUR);

    always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
        if (RESET_IN) begin
            setup_cnt <= 4'd0;
        end else if (!setup_i) begin
            setup_cnt <= 4'd0;
        end else if (rxval_i && setup_cnt < 4'(usb_pkg::SETUP_LEN)) begin
            setup_cnt <= setup_cnt + 4'd1;
        end
    end

    always_ff @(posedge PHY_CLKOUT) begin
        if (setup_i && rxval_i && setup_cnt < 4'(usb_pkg::SETUP_LEN)) begin
            setup_buf[setup_cnt[2:0]] <= rxdat_i;
        end
    end

    // request decode once the setup stage is over
    always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
        if (RESET_IN) begin
            state <= ST_IDLE;
        end else if (setup_i) begin
            state <= ST_SETUP;
        end else if (state == ST_SETUP) begin
            if (addr_match && is_set) begin
                state <= ST_WR_DATA;
            end else if (addr_match && is_get) begin
                state <= ST_RD_DATA;
            end else begin
                state <= ST_IDLE;
            end
        end
    end

    // ==================================================
    // data stage, shared byte index
    assign wr_run = (state == ST_WR_DATA) && rxact_i && ctrl_sel_i;
    assign rd_run = (state == ST_RD_DATA) && txact_i && ctrl_sel_i;
    assign wr_hit = wr_run && rxval_i && (idx < uvc_pkg::PROBE_LEN) &&
                    !(idx >= uvc_pkg::PAYLOAD_OFS &&
                      idx < uvc_pkg::PAYLOAD_OFS + uvc_pkg::FIELD32_LEN);  // payload size locked

    always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
        if (RESET_IN) begin
            idx <= '0;
        end else if (wr_run) begin
            if (rxval_i && idx != uvc_pkg::probe_idx_t'(uvc_pkg::PROBE_LEN)) begin
                idx <= idx + 6'd1;
            end
        end else if (rd_run) begin
            if (probe_send_o && txpop_i) begin
                idx <= idx + 6'd1;
            end
        end else begin
            idx <= '0;  // rewind between stages
        end
    end

    always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
        if (RESET_IN) begin
            probe_send_o <= 1'b0;
        end else if (setup_i && rxval_i) begin
            if (setup_cnt == 4'd0) begin
                probe_send_o <= 1'b0;  // new request drops any old reply
            end else if (setup_cnt == 4'd6 && addr_match && is_get) begin
                probe_send_o <= 1'b1;
            end
        end else if (rd_run && probe_send_o && txpop_i &&
                     idx == uvc_pkg::probe_idx_t'(uvc_pkg::PROBE_LEN - 1)) begin
            probe_send_o <= 1'b0;  // last byte taken
        end
    end

    // block store, defaults reload on reset
    always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
        if (RESET_IN) begin
            for (int i = 0; i < uvc_pkg::PROBE_LEN; i++) begin
                probe_mem[i] <= def_byte(i);
            end
        end else if (wr_hit) begin
            probe_mem[idx] <= rxdat_i;
        end
    end

    assign probe_dat_o = (idx < uvc_pkg::PROBE_LEN) ? probe_mem[idx] : 8'h00;

    idx_bound: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
        idx <= uvc_pkg::probe_idx_t'(uvc_pkg::PROBE_LEN));

endmodule

`default_nettype wire

// File: rtl/uvc_iso_sched.sv
// HS high-bandwidth iso, 3 packets per microframe; FIFO flags must be valid on PHY_CLKOUT
`timescale 1ns/1ps
`default_nettype none

module uvc_iso_sched #(
    parameter logic [usb_pkg::TXLEN_W-1:0] MAX_PACKET = 12'd1024
) (
    input  logic                        PHY_CLKOUT,
    input  logic                        RESET_IN,
    input  logic                        sof_i,
    input  logic                        video_end_i,
    input  logic                        txact_i,
    input  logic                        fifo_afull_i,
    input  logic                        fifo_aempty_i,
    input  logic                        fifo_empty_i,
    input  logic                        frame_dval_i,
    input  logic [usb_pkg::TXLEN_W-1:0] fifo_wnum_i,
    output logic [usb_pkg::TXLEN_W-1:0] iso_len_o,
    output logic                        iso_cork_o,
    output usb_pkg::iso_pid_e           iso_pid_o
);

    usb_pkg::iso_pid_e pid_q;

    // ==================================================
    // PID sequence, reloaded every microframe
    always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
        if (RESET_IN) begin
            pid_q <= usb_pkg::DATA2;
        end else if (sof_i) begin
            if (fifo_afull_i) begin
                pid_q <= usb_pkg::DATA2;  // three packets this frame
            end else if (fifo_aempty_i) begin
                pid_q <= usb_pkg::DATA0;  // single packet
            end else begin
                pid_q <= usb_pkg::DATA1;
            end
        end else if (video_end_i) begin
            case (pid_q)
                usb_pkg::DATA2: pid_q <= usb_pkg::DATA1;
                usb_pkg::DATA1: pid_q <= usb_pkg::DATA0;
                default:        pid_q <= usb_pkg::DATA0;  // last packet stays DATA0
            endcase
        end
    end

    assign iso_pid_o = pid_q;

    // ==================================================
    // packet length and cork, frozen during a transfer
    always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
        if (RESET_IN) begin
            iso_len_o  <= '0;
            iso_cork_o <= 1'b0;
        end else if (!txact_i) begin
            if (fifo_afull_i) begin
                iso_len_o  <= MAX_PACKET;
                iso_cork_o <= 1'b0;
            end else if (frame_dval_i || fifo_empty_i) begin
                iso_len_o  <= '0;  // hold off while the frame is still filling
                iso_cork_o <= 1'b1;
            end else if (fifo_aempty_i) begin
                iso_len_o  <= fifo_wnum_i;  // drain what is left
                iso_cork_o <= 1'b0;
            end else begin
                iso_len_o  <= MAX_PACKET;
                iso_cork_o <= 1'b0;
            end
        end
    end

    pid_legal: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
        pid_q inside {usb_pkg::DATA0, usb_pkg::DATA1, usb_pkg::DATA2});

endmodule

`default_nettype wire

// File: rtl/uvc_ep_arbiter.sv
// only EP0 and EP2 carry data; any other endpoint is answered with a corked zero-length packet
`timescale 1ns/1ps
`default_nettype none

module uvc_ep_arbiter (
    input  logic                        PHY_CLKOUT,
    input  logic                        RESET_IN,
    input  logic [usb_pkg::ENDPT_W-1:0] endpt_i,
    input  logic                        txact_i,
    input  logic                        txpop_i,
    input  logic [7:0]                  probe_dat_i,
    input  logic                        probe_send_i,
    input  logic [usb_pkg::TXLEN_W-1:0] iso_len_i,
    input  logic                        iso_cork_i,
    input  logic [7:0]                  fifo_rdat_i,
    output logic                        ctrl_sel_o,
    output logic                        video_end_o,
    output logic [7:0]                  txdat_o,
    output logic                        txval_o,
    output logic [usb_pkg::TXLEN_W-1:0] txdat_len_o,
    output logic                        txcork_o,
    output logic                        fifo_rden_o
);

    logic video_sel;
    logic txact_d;

    assign ctrl_sel_o = (endpt_i == usb_pkg::EP_CTRL);
    assign video_sel  = (endpt_i == usb_pkg::EP_VIDEO);

    // ==================================================
    // end of a video IN transfer
    always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
        if (RESET_IN) begin
            txact_d     <= 1'b0;
            video_end_o <= 1'b0;
        end else begin
            txact_d     <= txact_i;
            video_end_o <= txact_d && !txact_i && video_sel;  // falling edge on EP2
        end
    end

    // ==================================================
    // transmit port
    assign txdat_o     = ctrl_sel_o ? probe_dat_i : fifo_rdat_i;
    assign txval_o     = ctrl_sel_o && probe_send_i;
    assign fifo_rden_o = txact_i && txpop_i && video_sel;

    always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
        if (RESET_IN) begin
            txdat_len_o <= usb_pkg::TXLEN_W'(uvc_pkg::PROBE_LEN);
            txcork_o    <= 1'b0;
        end else if (txact_i) begin
            if (ctrl_sel_o) begin
                txdat_len_o <= '0;  // reply length owned by txval on EP0
            end
        end else if (ctrl_sel_o) begin
            txdat_len_o <= usb_pkg::TXLEN_W'(uvc_pkg::PROBE_LEN);
            txcork_o    <= 1'b0;
        end else if (video_sel) begin
            txdat_len_o <= iso_len_i;
            txcork_o    <= iso_cork_i;
        end else begin
            txdat_len_o <= '0;
            txcork_o    <= 1'b1;
        end
    end

    // endpoint stays on EP0 while a probe reply is in flight
    txval_ep0: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
        txval_o && txact_i |=> !txact_i || ctrl_sel_o);

endmodule

`default_nettype wire

// File: rtl/uvc_stream_top.sv
// UVC streaming glue above an external USB device controller and video FIFO; RESET_IN async high
`timescale 1ns/1ps
`default_nettype none

module uvc_stream_top #(
    parameter logic [31:0]                 MAX_FRAME_SIZE = 32'd614400,
    parameter logic [usb_pkg::TXLEN_W-1:0] MAX_PACKET     = 12'd1024
) (
    input  logic                        PHY_CLKOUT,
    input  logic                        RESET_IN,
    // device controller
    input  logic                        setup_i,
    input  logic [usb_pkg::ENDPT_W-1:0] endpt_i,
    input  logic [7:0]                  rxdat_i,
    input  logic                        rxval_i,
    input  logic                        rxact_i,
    input  logic                        txact_i,
    input  logic                        txpop_i,
    input  logic                        sof_i,
    // video FIFO
    input  logic                        fifo_afull_i,
    input  logic                        fifo_aempty_i,
    input  logic                        fifo_empty_i,
    input  logic [usb_pkg::TXLEN_W-1:0] fifo_wnum_i,
    input  logic [7:0]                  fifo_rdat_i,
    input  logic                        frame_dval_i,
    // transmit port
    output logic [7:0]                  txdat_o,
    output logic                        txval_o,
    output logic [usb_pkg::TXLEN_W-1:0] txdat_len_o,
    output logic                        txcork_o,
    output usb_pkg::iso_pid_e           txiso_pid_o,
    output logic                        fifo_rden_o
);

    logic                        ctrl_sel;
    logic                        video_end;
    logic [7:0]                  probe_dat;
    logic                        probe_send;
    logic [usb_pkg::TXLEN_W-1:0] iso_len;
    logic                        iso_cork;

    uvc_probe_ctrl #(
        .MAX_FRAME_SIZE (MAX_FRAME_SIZE)
    ) u_probe_ctrl (
        .PHY_CLKOUT   (PHY_CLKOUT),
        .RESET_IN     (RESET_IN),
        .setup_i      (setup_i),
        .ctrl_sel_i   (ctrl_sel),
        .rxdat_i      (rxdat_i),
        .rxval_i      (rxval_i),
        .rxact_i      (rxact_i),
        .txact_i      (txact_i),
        .txpop_i      (txpop_i),
        .probe_dat_o  (probe_dat),
        .probe_send_o (probe_send)
    );

    uvc_iso_sched #(
        .MAX_PACKET (MAX_PACKET)
    ) u_iso_sched (
        .PHY_CLKOUT    (PHY_CLKOUT),
        .RESET_IN      (RESET_IN),
        .sof_i         (sof_i),
        .video_end_i   (video_end),
        .txact_i       (txact_i),
        .fifo_afull_i  (fifo_afull_i),
        .fifo_aempty_i (fifo_aempty_i),
        .fifo_empty_i  (fifo_empty_i),
        .frame_dval_i  (frame_dval_i),
        .fifo_wnum_i   (fifo_wnum_i),
        .iso_len_o     (iso_len),
        .iso_cork_o    (iso_cork),
        .iso_pid_o     (txiso_pid_o)  // straight to the controller
    );

    uvc_ep_arbiter u_ep_arbiter (
        .PHY_CLKOUT   (PHY_CLKOUT),
        .RESET_IN     (RESET_IN),
        .endpt_i      (endpt_i),
        .txact_i      (txact_i),
        .txpop_i      (txpop_i),
        .probe_dat_i  (probe_dat),
        .probe_send_i (probe_send),
        .iso_len_i    (iso_len),
        .iso_cork_i   (iso_cork),
        .fifo_rdat_i  (fifo_rdat_i),
        .ctrl_sel_o   (ctrl_sel),
        .video_end_o  (video_end),
        .txdat_o      (txdat_o),
        .txval_o      (txval_o),
        .txdat_len_o  (txdat_len_o),
        .txcork_o     (txcork_o),
        .fifo_rden_o  (fifo_rden_o)
    );

endmodule

`default_nettype wire

// File: sim/uvc_clk_gen.sv
// testbench only; free-running clock from time 0, reset released 1 ns after the last reset edge
`timescale 1ns/1ps
`default_nettype none

module uvc_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;  // same skew as the stimulus
    end

endmodule

`default_nettype wire

// File: sim/tb_uvc_stream.sv
// assumes MAX_FRAME_SIZE 614400 and MAX_PACKET 1024; probe replies use a fixed wLength of 34
`timescale 1ns/1ps
`default_nettype none

module tb_uvc_stream;

    localparam logic [31:0] MAX_FRAME_SIZE = 32'd614400;
    localparam logic [11:0] MAX_PACKET     = 12'd1024;
    localparam int          PERIOD_NS      = 10;
    localparam int          DRV_DLY        = 1;
    localparam int          SEED           = 52788;
    localparam int          BLK_LEN        = 34;
    localparam int          MAX_POPS       = 40;

    localparam logic [3:0] PID_DATA0 = 4'b0011;
    localparam logic [3:0] PID_DATA1 = 4'b1011;
    localparam logic [3:0] PID_DATA2 = 4'b0111;
    localparam logic [7:0] REQ_SET_CUR = 8'h01;
    localparam logic [7:0] REQ_GET_CUR = 8'h81;

    // ==================================================
    // run length in clock cycles per test
    localparam int PID_ROUNDS  = 8;
    localparam int LEN_ROUNDS  = 16;
    localparam int RDEN_ROUNDS = 24;
    localparam int RUN_CYCLES  = 4 + 60 + 120 + 60 + PID_ROUNDS * 20 +
                                 (LEN_ROUNDS + 8) * 4 + RDEN_ROUNDS + 10;
    localparam int WATCHDOG_NS = (RUN_CYCLES + 200) * PERIOD_NS;  // plus margin

    logic        PHY_CLKOUT;
    logic        RESET_IN;
    logic        setup_i;
    logic [3:0]  endpt_i;
    logic [7:0]  rxdat_i;
    logic        rxval_i;
    logic        rxact_i;
    logic        txact_i;
    logic        txpop_i;
    logic        sof_i;
    logic        fifo_afull_i;
    logic        fifo_aempty_i;
    logic        fifo_empty_i;
    logic [11:0] fifo_wnum_i;
    logic [7:0]  fifo_rdat_i;
    logic        frame_dval_i;
    logic [7:0]  txdat_o;
    logic        txval_o;
    logic [11:0] txdat_len_o;
    logic        txcork_o;
    logic [3:0]  txiso_pid_o;
    logic        fifo_rden_o;

    logic [7:0]  wr_data [BLK_LEN];
    bit          blk_written;
    logic [7:0]  exp_q [$];
    logic [7:0]  exp_byte;
    int          err_cnt;
    int          check_cnt;
    int          test_err_base;
    int          tests_run;
    int          tests_failed;
    logic [3:0]  exp_pid;
    logic [12:0] exp_lc;
    int          ep_pick;

    uvc_clk_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (4)
    ) u_clk_gen (
        .clk_o (PHY_CLKOUT),
        .rst_o (RESET_IN)
    );

    uvc_stream_top #(
        .MAX_FRAME_SIZE (MAX_FRAME_SIZE),
        .MAX_PACKET     (MAX_PACKET)
    ) u_uvc_stream_top (
        .PHY_CLKOUT    (PHY_CLKOUT),
        .RESET_IN      (RESET_IN),
        .setup_i       (setup_i),
        .endpt_i       (endpt_i),
        .rxdat_i       (rxdat_i),
        .rxval_i       (rxval_i),
        .rxact_i       (rxact_i),
        .txact_i       (txact_i),
        .txpop_i       (txpop_i),
        .sof_i         (sof_i),
        .fifo_afull_i  (fifo_afull_i),
        .fifo_aempty_i (fifo_aempty_i),
        .fifo_empty_i  (fifo_empty_i),
        .fifo_wnum_i   (fifo_wnum_i),
        .fifo_rdat_i   (fifo_rdat_i),
        .frame_dval_i  (frame_dval_i),
        .txdat_o       (txdat_o),
        .txval_o       (txval_o),
        .txdat_len_o   (txdat_len_o),
        .txcork_o      (txcork_o),
        .txiso_pid_o   (txiso_pid_o),
        .fifo_rden_o   (fifo_rden_o)
    );

    // ==================================================
    // reference model
    function automatic logic [7:0] expected_probe_byte(input int pos, input bit written,
                                                       input logic [7:0] wr_byte);
        logic [31:0] field;
        int          base;
        field = 32'd0;
        base  = pos;
        if (written && !(pos >= 22 && pos <= 25)) begin
            return wr_byte;  // payload size is read-only
        end
        if (pos == 2 || pos == 3) begin
            field = 32'd1;  // format and frame index
        end else if (pos >= 4 && pos <= 7) begin
            field = 32'd333333;
            base  = 4;
        end else if (pos >= 18 && pos <= 21) begin
            field = MAX_FRAME_SIZE;
            base  = 18;
        end else if (pos >= 22 && pos <= 25) begin
            field = 32'd1024;
            base  = 22;
        end else if (pos >= 26 && pos <= 29) begin
            field = 32'd60000000;
            base  = 26;
        end
        return field[8 * (pos - base) +: 8];  // little endian
    endfunction

    function automatic logic [3:0] pid_after_sof(input logic afull, input logic aempty);
        if (afull) begin
            return PID_DATA2;
        end
        return aempty ? PID_DATA0 : PID_DATA1;
    endfunction

    function automatic logic [3:0] pid_after_packet(input logic [3:0] pid);
        return (pid == PID_DATA2) ? PID_DATA1 : PID_DATA0;
    endfunction

    // {cork, len} for the transmit port with txact low
    function automatic logic [12:0] expected_len_cork(input logic [3:0] ep, input logic afull,
                                                      input logic aempty, input logic empty,
                                                      input logic dval, input logic [11:0] wnum);
        if (ep == 4'd0) begin
            return {1'b0, 12'd34};
        end else if (ep != 4'd2) begin
            return {1'b1, 12'd0};
        end else if (afull) begin
            return {1'b0, MAX_PACKET};
        end else if (dval || empty) begin
            return {1'b1, 12'd0};
        end else if (aempty) begin
            return {1'b0, wnum};
        end
        return {1'b0, MAX_PACKET};
    endfunction

    // ==================================================
    // checking helpers
    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("mismatch at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt == test_err_base) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    // compare process checks one expected byte per EP0 pop
    always @(negedge PHY_CLKOUT) begin
        if (txact_i && txpop_i && endpt_i == 4'd0 && exp_q.size() > 0) begin
            exp_byte = exp_q.pop_front();
            expect_equal("txval_o", txval_o, 1'b1);
            expect_equal("txdat_o", txdat_o, exp_byte);
        end
    end

    // ==================================================
    // stimulus tasks
    task automatic send_setup(input logic [7:0] rtype, input logic [7:0] breq,
                              input logic [7:0] sel, input logic [7:0] intf);
        logic [7:0] pkt [8];
        pkt = '{rtype, breq, 8'h00, sel, intf, 8'h00, 8'h22, 8'h00};
        for (int i = 0; i < 8; i++) begin
            @(posedge PHY_CLKOUT);
            #DRV_DLY;
            endpt_i = 4'd0;
            setup_i = 1'b1;
            rxval_i = 1'b1;
            rxdat_i = pkt[i];
        end
        @(posedge PHY_CLKOUT);
        #DRV_DLY;
        setup_i = 1'b0;
        rxval_i = 1'b0;
        rxdat_i = 8'h00;
        @(posedge PHY_CLKOUT);  // request decode
        #DRV_DLY;
    endtask

    task automatic send_probe_data();
        @(posedge PHY_CLKOUT);
        #DRV_DLY;
        rxact_i = 1'b1;
        for (int i = 0; i < BLK_LEN; i++) begin
            rxval_i = 1'b1;
            rxdat_i = wr_data[i];
            @(posedge PHY_CLKOUT);
            #DRV_DLY;
        end
        rxval_i = 1'b0;
        rxact_i = 1'b0;
    endtask

    task automatic read_probe_reply();
        int pops;
        bit done;
        pops = 0;
        done = 1'b0;
        for (int i = 0; i < BLK_LEN; i++) begin
            exp_q.push_back(expected_probe_byte(i, blk_written, wr_data[i]));
        end
        @(posedge PHY_CLKOUT);
        #DRV_DLY;
        endpt_i = 4'd0;
        txact_i = 1'b1;
        txpop_i = 1'b1;  // controller pops every cycle
        while (!done && pops <= MAX_POPS) begin
            @(negedge PHY_CLKOUT);
            if (txval_o) begin
                pops++;
            end else begin
                done = 1'b1;
            end
        end
        @(posedge PHY_CLKOUT);
        #DRV_DLY;
        txact_i = 1'b0;
        txpop_i = 1'b0;
        assert (done) else begin
            err_cnt++;
            $display("txval_o stayed high for more than %0d pops of the probe reply", MAX_POPS);
        end
        expect_equal("pops before txval_o fell", pops, BLK_LEN);
        exp_q.delete();
    endtask

    task automatic expect_no_reply();
        @(posedge PHY_CLKOUT);
        #DRV_DLY;
        endpt_i = 4'd0;
        txact_i = 1'b1;
        txpop_i = 1'b1;
        repeat (12) begin
            @(negedge PHY_CLKOUT);
            expect_equal("txval_o", txval_o, 1'b0);
        end
        @(posedge PHY_CLKOUT);
        #DRV_DLY;
        txact_i = 1'b0;
        txpop_i = 1'b0;
    endtask

    // ==================================================
    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        setup_i       = 1'b0;
        endpt_i       = 4'd0;
        rxdat_i       = 8'h00;
        rxval_i       = 1'b0;
        rxact_i       = 1'b0;
        txact_i       = 1'b0;
        txpop_i       = 1'b0;
        sof_i         = 1'b0;
        fifo_afull_i  = 1'b0;
        fifo_aempty_i = 1'b0;
        fifo_empty_i  = 1'b0;
        fifo_wnum_i   = 12'd0;
        fifo_rdat_i   = 8'h00;
        frame_dval_i  = 1'b0;
        blk_written   = 1'b0;
        err_cnt       = 0;
        check_cnt     = 0;
        test_err_base = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (int i = 0; i < BLK_LEN; i++) begin
            wr_data[i] = 8'h00;
        end
        @(negedge RESET_IN);

        // test 1 checks reset values and the default block
        @(negedge PHY_CLKOUT);
        expect_equal("txval_o", txval_o, 1'b0);
        expect_equal("txcork_o", txcork_o, 1'b0);
        expect_equal("txdat_len_o", txdat_len_o, 12'd34);
        expect_equal("txiso_pid_o", txiso_pid_o, PID_DATA2);
        send_setup(8'hA1, REQ_GET_CUR, 8'h01, 8'h01);
        read_probe_reply();
        end_test("test 1 default probe read");

        // test 2 writes the block then reads it back
        for (int i = 0; i < BLK_LEN; i++) begin
            wr_data[i] = 8'($urandom);
        end
        send_setup(8'h21, REQ_SET_CUR, 8'h01, 8'h01);
        send_probe_data();
        blk_written = 1'b1;
        send_setup(8'hA1, REQ_GET_CUR, 8'h01, 8'h01);
        read_probe_reply();
        end_test("test 2 probe write and readback");

        // test 3 uses the wrong interface and then the wrong selector
        send_setup(8'hA1, REQ_GET_CUR, 8'h01, 8'h02);
        expect_no_reply();
        send_setup(8'hA1, REQ_GET_CUR, 8'h02, 8'h01);
        expect_no_reply();
        end_test("test 3 misaddressed probe read");

        // test 4 PID per microframe
        for (int n = 0; n < PID_ROUNDS; n++) begin
            @(posedge PHY_CLKOUT);
            #DRV_DLY;
            endpt_i       = 4'd2;
            fifo_afull_i  = 1'($urandom % 2);
            fifo_aempty_i = 1'($urandom % 2);
            sof_i         = 1'b1;
            exp_pid       = pid_after_sof(fifo_afull_i, fifo_aempty_i);
            @(posedge PHY_CLKOUT);
            #DRV_DLY;
            sof_i = 1'b0;
            @(negedge PHY_CLKOUT);
            expect_equal("txiso_pid_o", txiso_pid_o, exp_pid);
            for (int p = 0; p < 3; p++) begin
                @(posedge PHY_CLKOUT);
                #DRV_DLY;
                txact_i = 1'b1;
                @(posedge PHY_CLKOUT);
                #DRV_DLY;
                txact_i = 1'b0;
                repeat (2) @(posedge PHY_CLKOUT);  // fall detect then PID step
                @(negedge PHY_CLKOUT);
                exp_pid = pid_after_packet(exp_pid);
                expect_equal("txiso_pid_o", txiso_pid_o, exp_pid);
            end
        end
        end_test("test 4 iso PID sequence");

        // test 5 length and cork per endpoint
        for (int n = 0; n < LEN_ROUNDS + 8; n++) begin
            @(posedge PHY_CLKOUT);
            #DRV_DLY;
            ep_pick = $urandom % 14 + 1;
            endpt_i = (n < LEN_ROUNDS) ? 4'd2 : (n % 2 == 0) ? 4'd0 :
                      4'((ep_pick >= 2) ? ep_pick + 1 : ep_pick);  // endpoint 1 or 3..15
            txact_i       = 1'b0;
            fifo_afull_i  = ($urandom % 3 == 0);
            fifo_aempty_i = ($urandom % 2 == 0);
            fifo_empty_i  = ($urandom % 3 == 0);
            frame_dval_i  = ($urandom % 3 == 0);
            fifo_wnum_i   = 12'($urandom);
            exp_lc = expected_len_cork(endpt_i, fifo_afull_i, fifo_aempty_i, fifo_empty_i,
                                       frame_dval_i, fifo_wnum_i);
            repeat (2) @(posedge PHY_CLKOUT);  // scheduler then arbiter register
            @(negedge PHY_CLKOUT);
            expect_equal("txdat_len_o", txdat_len_o, exp_lc[11:0]);
            expect_equal("txcork_o", txcork_o, exp_lc[12]);
        end
        end_test("test 5 transfer length and cork");

        // test 6 FIFO read strobe and data path
        for (int n = 0; n < RDEN_ROUNDS; n++) begin
            @(posedge PHY_CLKOUT);
            #DRV_DLY;
            endpt_i     = ($urandom % 4 == 0) ? 4'd3 : 4'd2;  // mostly EP2
            txact_i     = ($urandom % 4 != 0);
            txpop_i     = 1'($urandom % 2);
            fifo_rdat_i = 8'($urandom);
            @(negedge PHY_CLKOUT);
            expect_equal("fifo_rden_o", fifo_rden_o, txact_i && txpop_i && endpt_i == 4'd2);
            if (txact_i && txpop_i && endpt_i == 4'd2) begin
                expect_equal("txdat_o", txdat_o, fifo_rdat_i);
            end
        end
        @(posedge PHY_CLKOUT);
        #DRV_DLY;
        txact_i = 1'b0;
        txpop_i = 1'b0;
        end_test("test 6 FIFO read strobe");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/usb_pkg.sv
rtl/uvc_pkg.sv
rtl/uvc_probe_ctrl.sv
rtl/uvc_iso_sched.sv
rtl/uvc_ep_arbiter.sv
rtl/uvc_stream_top.sv
sim/uvc_clk_gen.sv
sim/tb_uvc_stream.sv

// File: Bender.yml
package:
  name: uvc_stream

sources:
  - files:
      - rtl/usb_pkg.sv
      - rtl/uvc_pkg.sv
      - rtl/uvc_probe_ctrl.sv
      - rtl/uvc_iso_sched.sv
      - rtl/uvc_ep_arbiter.sv
      - rtl/uvc_stream_top.sv
  - target: simulation
    files:
      - sim/uvc_clk_gen.sv
      - sim/tb_uvc_stream.sv
